// ==== all.f ====
hw/busMapPkg.sv
hw/bankMapPkg.sv
hw/busCycleCapture.sv
hw/boardRegisters.sv
hw/palpromPager.sv
hw/bankSelect.sv
hw/integraBoard.sv
tests/tbClockGen.sv
tests/integraBoardTb.sv

// ==== Makefile ====
# Any of these can be overridden on the command line, e.g. make test TOP=integraBoardTb
VERILATOR ?= verilator
TOP ?= integraBoardTb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing
PASS_TEXT ?= Test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/integraBoardTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module integraBoardTb import busMapPkg::*, bankMapPkg::*; ();

	localparam logic [31:0] randomSeed = 32'h8116;
	localparam int resetTimeout = 20;
	localparam int runTimeout = 100000;
	// Jumper fit used for the whole run
	// A 1 on any jumper selects ROM
	localparam logic [15:0] wpJumpers = 16'h5AC3;
	localparam logic [3:0] beebJumpers = 4'b0011;
	localparam logic [7:0] socketJumpers = 8'b1100_0110;

	logic cc4Clk;
	logic bbc_nRST;
	logic [addrWidth-1:0] cpuAddress;
	logic [dataWidth-1:0] cpuData;
	logic cpuRnw;
	logic cpuPhi1;
	logic [15:0] ramWriteProt;
	logic [3:0] beebRomSel;
	logic [7:0] integraRomSel;
	logic [dataWidth-1:0] dataOut;
	logic dataOutEn;
	logic nRomBankSel0to3;
	logic [7:0] nRomBankSel;
	logic nRamCe;
	ramBankT ramAddress;
	logic nWds;
	logic nRds;
	logic nDbufCe;
	logic nDbufDir;
	logic toBbcPhi1;
	logic toBbcRnw;
	logic toBbcRd0;
	logic toBbcRd1;
	logic rtcAs;
	logic rtcDs;

	// Outputs as seen in the middle of the phi2 high half of the last cycle
	logic [dataWidth-1:0] seenDataOut;
	logic seenDataOutEn;
	logic seenRomSel0to3;
	logic [7:0] seenRomSel;
	logic seenRamCe;
	ramBankT seenRamAddress;
	logic seenWds;
	logic seenRds;
	logic seenDbufCe;
	logic seenDbufDir;
	logic seenToBbcPhi1;
	logic seenToBbcRnw;
	logic seenRd0;
	logic seenRd1;
	logic seenRtcAs;
	logic seenRtcDs;

	int checkCount;
	int errorCount;
	int testErrors;
	logic resetDone;

	tbClockGen i_clockGen (
		.cc4Clk  (cc4Clk),
		.bbc_nRST(bbc_nRST)
	);

	integraBoard i_dut (
		.cc4Clk(cc4Clk), .bbc_nRST(bbc_nRST), .cpuAddress(cpuAddress), .cpuData(cpuData),
		.cpuRnw(cpuRnw), .cpuPhi1(cpuPhi1), .ramWriteProt(ramWriteProt),
		.beebRomSel(beebRomSel), .integraRomSel(integraRomSel), .dataOut(dataOut),
		.dataOutEn(dataOutEn), .nRomBankSel0to3(nRomBankSel0to3), .nRomBankSel(nRomBankSel),
		.nRamCe(nRamCe), .ramAddress(ramAddress), .nWds(nWds), .nRds(nRds),
		.nDbufCe(nDbufCe), .nDbufDir(nDbufDir), .toBbcPhi1(toBbcPhi1), .toBbcRnw(toBbcRnw),
		.toBbcRd0(toBbcRd0), .toBbcRd1(toBbcRd1), .rtcAs(rtcAs), .rtcDs(rtcDs)
	);

	task automatic checkBit(input string name, input logic got, input logic expected);
		checkCount++;
		if (got !== expected) begin
			errorCount++;
			testErrors++;
			$display("ERROR at %0t ns: %s is %b, expected %b", $time, name, got, expected);
		end
	endtask

	task automatic checkByte(input string name, input logic [dataWidth-1:0] got,
			input logic [dataWidth-1:0] expected);
		checkCount++;
		if (got !== expected) begin
			errorCount++;
			testErrors++;
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, expected);
		end
	endtask

	task automatic checkRamBank(input string name, input ramBankT got, input ramBankT expected);
		checkCount++;
		if (got !== expected) begin
			errorCount++;
			testErrors++;
			$display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, got, expected);
		end
	endtask

	task automatic finishTest(input string name);
		$display("%s: %0d errors", name, testErrors);
		testErrors = 0;
	endtask

	task automatic waitForReset(output logic released);
		int waited;
		waited = 0;
		while (bbc_nRST !== 1'b1 && waited < resetTimeout) begin
			@(negedge cc4Clk);
			waited++;
		end
		released = (bbc_nRST === 1'b1);
	endtask

	// One CPU cycle is entered and left on a falling clock edge
	// Phi2 is high for four rising edges and low for four more
	task automatic busCycle(input logic [addrWidth-1:0] addr,
			input logic [dataWidth-1:0] data, input logic rnw);
		cpuAddress = addr;
		cpuData = data;
		cpuRnw = rnw;
		cpuPhi1 = 1'b0;
		repeat (2) @(negedge cc4Clk);
		seenDataOut = dataOut;
		seenDataOutEn = dataOutEn;
		seenRomSel0to3 = nRomBankSel0to3;
		seenRomSel = nRomBankSel;
		seenRamCe = nRamCe;
		seenRamAddress = ramAddress;
		seenWds = nWds;
		seenRds = nRds;
		seenDbufCe = nDbufCe;
		seenDbufDir = nDbufDir;
		seenToBbcPhi1 = toBbcPhi1;
		seenToBbcRnw = toBbcRnw;
		seenRd0 = toBbcRd0;
		seenRd1 = toBbcRd1;
		seenRtcAs = rtcAs;
		seenRtcDs = rtcDs;
		repeat (2) @(negedge cc4Clk);
		// Address and data stay put through phi1 as on the real bus
		cpuPhi1 = 1'b1;
		repeat (4) @(negedge cc4Clk);
	endtask

	task automatic writeCycle(input logic [addrWidth-1:0] addr, input logic [dataWidth-1:0] data);
		busCycle(addr, data, 1'b0);
	endtask

	task automatic readCycle(input logic [addrWidth-1:0] addr);
		busCycle(addr, 8'h00, 1'b1);
	endtask

	// Write protect bytes read back as the inverted jumpers after reset
	task automatic resetStateTest();
		checkBit("dataOutEn", dataOutEn, 1'b0);
		readCycle(16'hFE3A);
		checkBit("dataOutEn", seenDataOutEn, 1'b1);
		checkByte("dataOut", seenDataOut, ~wpJumpers[7:0]);
		checkBit("nRds", seenRds, 1'b0);
		checkBit("nDbufCe", seenDbufCe, 1'b0);
		checkBit("nDbufDir", seenDbufDir, 1'b1);
		readCycle(16'hFE3B);
		checkBit("dataOutEn", seenDataOutEn, 1'b1);
		checkByte("dataOut", seenDataOut, ~wpJumpers[15:8]);
		readCycle(16'h8000);
		checkBit("dataOutEn", seenDataOutEn, 1'b0);
		readCycle(16'hFE30);
		checkBit("dataOutEn", seenDataOutEn, 1'b0);
		finishTest("reset state");
	endtask

	task automatic romLatchTest();
		ctlByteT latch;
		romBankT rom;
		logic [31:0] draw;
		logic expBeeb;
		logic expSocket;
		logic [7:0] expSockets;
		for (int n = 0; n < 12; n++) begin
			draw = $urandom;
			rom = draw[3:0];
			latch = '0;
			latch.romLatchView.romNum = rom;
			writeCycle(16'hFE30, latch);
			readCycle(16'h8000);
			// Motherboard owns banks 0..3 and the sockets own 8..15 when jumpered
			expBeeb = (rom < 4'd4) && beebJumpers[rom[1:0]];
			expSocket = rom[3] && socketJumpers[rom[2:0]];
			expSockets = 8'hFF;
			if (expSocket) begin
				expSockets[rom[2:0]] = 1'b0;
			end
			checkBit("nRomBankSel0to3", seenRomSel0to3, !expBeeb);
			checkByte("nRomBankSel", seenRomSel, expSockets);
			checkBit("nRamCe", seenRamCe, expBeeb || expSocket);
			// The buffer stays off only while a motherboard ROM drives the bus
			checkBit("nDbufCe", seenDbufCe, expBeeb);
			if (!expBeeb && !expSocket) begin
				checkRamBank("ramAddress", seenRamAddress, {1'b0, rom});
			end
			checkBit("toBbcRd0", seenRd0, rom[0]);
			checkBit("toBbcRd1", seenRd1, rom[1]);
		end
		writeCycle(16'hFE30, 8'h00);
		finishTest("rom latch");
	endtask

	task automatic writeProtectTest();
		ctlByteT latch;
		logic [31:0] draw;
		logic [7:0] wp;
		draw = $urandom;
		wp = draw[7:0];
		writeCycle(16'hFE3A, wp);
		readCycle(16'hFE3A);
		checkByte("dataOut", seenDataOut, wp);
		// The high byte keeps its reset value
		readCycle(16'hFE3B);
		checkByte("dataOut", seenDataOut, ~wpJumpers[15:8]);
		for (int bank = 0; bank < 8; bank++) begin
			latch = '0;
			latch.romLatchView.romNum = bank[3:0];
			writeCycle(16'hFE30, latch);
			writeCycle(16'h8000, 8'h00);
			checkBit("nWds", seenWds, !wp[bank]);
			checkBit("nRds", seenRds, 1'b1);
			checkBit("nDbufDir", seenDbufDir, 1'b0);
		end
		writeCycle(16'hFE30, 8'h00);
		finishTest("write protect");
	endtask

	// Address bit 14 picks the half of the 32 KB block, so &4000 lands in bank 17
	task automatic shadowPrivateTest();
		ctlByteT ctl;
		ctlByteT latch;
		ctl = '0;
		ctl.accessCtlView.shEn = 1'b1;
		writeCycle(16'hFE34, ctl);
		writeCycle(16'h3000, 8'h55);
		checkRamBank("ramAddress", seenRamAddress, 5'd16);
		checkBit("nRamCe", seenRamCe, 1'b0);
		checkBit("toBbcPhi1", seenToBbcPhi1, 1'b1);
		// The motherboard sees a read while the CPU writes shadow RAM
		checkBit("toBbcRnw", seenToBbcRnw, 1'b1);
		checkBit("nWds", seenWds, 1'b0);
		readCycle(16'h4000);
		checkRamBank("ramAddress", seenRamAddress, 5'd17);
		latch = '0;
		latch.romLatchView.privEn = 1'b1;
		writeCycle(16'hFE30, latch);
		ctl.accessCtlView.privS8 = 1'b1;
		writeCycle(16'hFE34, ctl);
		// Private RAM hides motherboard bank 0 from &9000 to &AFFF
		readCycle(16'h9000);
		checkRamBank("ramAddress", seenRamAddress, 5'd16);
		checkBit("nRamCe", seenRamCe, 1'b0);
		checkBit("nRomBankSel0to3", seenRomSel0to3, 1'b1);
		readCycle(16'hA000);
		checkRamBank("ramAddress", seenRamAddress, 5'd16);
		readCycle(16'hB000);
		checkBit("nRomBankSel0to3", seenRomSel0to3, 1'b0);
		checkBit("nDbufCe", seenDbufCe, 1'b1);
		writeCycle(16'hFE30, 8'h00);
		writeCycle(16'hFE34, 8'h00);
		// With shadow off the screen write goes out to the motherboard untouched
		writeCycle(16'h3000, 8'hAA);
		checkBit("nRamCe", seenRamCe, 1'b1);
		checkBit("toBbcPhi1", seenToBbcPhi1, 1'b0);
		checkBit("toBbcRnw", seenToBbcRnw, 1'b0);
		checkBit("nWds", seenWds, 1'b1);
		checkBit("nDbufCe", seenDbufCe, 1'b1);
		finishTest("shadow and private");
	endtask

	task automatic pagingTest();
		ctlByteT latch;
		// Socket 10 goes to RAM so bank 10 holds the paged image
		integraRomSel[2] = 1'b0;
		latch = '0;
		latch.romLatchView.romNum = 4'd10;
		writeCycle(16'hFE30, latch);
		readCycle(16'h8000);
		checkRamBank("ramAddress", seenRamAddress, 5'd10);
		checkBit("nRamCe", seenRamCe, 1'b0);
		readCycle(16'h91E0);
		readCycle(16'h8000);
		checkRamBank("ramAddress", seenRamAddress, 5'd22);
		readCycle(16'h8820);
		readCycle(16'h8000);
		checkRamBank("ramAddress", seenRamAddress, 5'd23);
		readCycle(16'h92C0);
		readCycle(16'h8000);
		checkRamBank("ramAddress", seenRamAddress, 5'd24);
		// Plain reads and trigger writes leave the page alone
		readCycle(16'h9000);
		writeCycle(16'h9340, 8'h00);
		readCycle(16'h8000);
		checkRamBank("ramAddress", seenRamAddress, 5'd24);
		readCycle(16'h9340);
		readCycle(16'h8000);
		checkRamBank("ramAddress", seenRamAddress, 5'd10);
		writeCycle(16'hFE30, 8'h00);
		integraRomSel = socketJumpers;
		finishTest("rom paging");
	endtask

	task automatic clockChipTest();
		writeCycle(16'hFE38, 8'h0D);
		checkBit("rtcAs", seenRtcAs, 1'b1);
		checkBit("rtcDs", seenRtcDs, 1'b0);
		readCycle(16'hFE3D);
		checkBit("rtcDs", seenRtcDs, 1'b1);
		checkBit("rtcAs", seenRtcAs, 1'b0);
		readCycle(16'hFE38);
		checkBit("rtcAs", seenRtcAs, 1'b0);
		finishTest("clock chip");
	endtask

	// Guards against a stalled clock or a runaway test
	initial begin
		#runTimeout;
		$display("Simulation did not finish within %0d ns", runTimeout);
		$display("Test failed");
		$finish;
	end

	initial begin
		cpuAddress = '0;
		cpuData = '0;
		cpuRnw = 1'b1;
		cpuPhi1 = 1'b1;
		ramWriteProt = wpJumpers;
		beebRomSel = beebJumpers;
		integraRomSel = socketJumpers;
		checkCount = 0;
		errorCount = 0;
		testErrors = 0;
		void'($urandom(randomSeed));
		waitForReset(resetDone);
		if (!resetDone) begin
			$display("Reset was never released by the clock generator");
			$display("Test failed");
		end else begin
			@(negedge cc4Clk);
			resetStateTest();
			romLatchTest();
			writeProtectTest();
			shadowPrivateTest();
			pagingTest();
			clockChipTest();
			$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
			if (errorCount == 0) begin
				$display("Test passed");
			end else begin
				$display("Test failed");
			end
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/tbClockGen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbClockGen (
	output logic cc4Clk,
	output logic bbc_nRST
);

	// 8 ns period for the board system clock
	localparam int halfPeriod = 4;
	// Number of rising edges that see reset asserted
	localparam int resetCycles = 3;

	initial begin
		cc4Clk = 1'b0;
		forever #halfPeriod cc4Clk = ~cc4Clk;
	end

	// Release on a falling edge so the first active edge sees a clean level
	initial begin
		bbc_nRST = 1'b0;
		repeat (resetCycles) @(posedge cc4Clk);
		@(negedge cc4Clk);
		bbc_nRST = 1'b1;
	end

endmodule

`default_nettype wire

// ==== hw/integraBoard.sv ====
`timescale 1ns/10ps
`default_nettype none

module integraBoard import busMapPkg::*, bankMapPkg::*; (
	input  logic                 cc4Clk,
	input  logic                 bbc_nRST,
	input  logic [addrWidth-1:0] cpuAddress,
	input  logic [dataWidth-1:0] cpuData,
	input  logic                 cpuRnw,
	input  logic                 cpuPhi1,
	input  logic [15:0]          ramWriteProt,
	input  logic [3:0]           beebRomSel,
	input  logic [7:0]           integraRomSel,
	output logic [dataWidth-1:0] dataOut,
	output logic                 dataOutEn,
	output logic                 nRomBankSel0to3,
	output logic [7:0]           nRomBankSel,
	output logic                 nRamCe,
	output ramBankT              ramAddress,
	output logic                 nWds,
	output logic                 nRds,
	output logic                 nDbufCe,
	output logic                 nDbufDir,
	output logic                 toBbcPhi1,
	output logic                 toBbcRnw,
	output logic                 toBbcRd0,
	output logic                 toBbcRd1,
	output logic                 rtcAs,
	output logic                 rtcDs
);

	// Finished CPU cycle
	logic cycleEnd;
	logic [addrWidth-1:0] cycleAddr;
	ctlByteT cycleData;
	logic cycleRead;

	// Latched board state
	romBankT romNumber;
	logic privEn;
	logic memSel;
	logic privS8;
	logic privS4;
	logic privS1;
	logic shEn;
	logic [15:0] writeProt;

	// Pager loop
	pageT page;
	logic romRead;

	busCycleCapture i_capture (
		.cc4Clk    (cc4Clk),
		.bbc_nRST  (bbc_nRST),
		.cpuPhi1   (cpuPhi1),
		.cpuRnw    (cpuRnw),
		.cpuAddress(cpuAddress),
		.cpuData   (cpuData),
		.cycleEnd  (cycleEnd),
		.cycleAddr (cycleAddr),
		.cycleData (cycleData),
		.cycleRead (cycleRead)
	);

	boardRegisters i_registers (
		.cc4Clk      (cc4Clk),
		.bbc_nRST    (bbc_nRST),
		.cycleEnd    (cycleEnd),
		.cycleAddr   (cycleAddr),
		.cycleData   (cycleData),
		.cycleRead   (cycleRead),
		.cpuAddress  (cpuAddress),
		.cpuPhi1     (cpuPhi1),
		.cpuRnw      (cpuRnw),
		.ramWriteProt(ramWriteProt),
		.romNumber   (romNumber),
		.privEn      (privEn),
		.memSel      (memSel),
		.privS8      (privS8),
		.privS4      (privS4),
		.privS1      (privS1),
		.shEn        (shEn),
		.writeProt   (writeProt),
		.dataOut     (dataOut),
		.dataOutEn   (dataOutEn)
	);

	palpromPager i_pager (
		.cc4Clk   (cc4Clk),
		.bbc_nRST (bbc_nRST),
		.cycleEnd (cycleEnd),
		.cycleAddr(cycleAddr),
		.cycleRead(cycleRead),
		.romRead  (romRead),
		.page     (page)
	);

	bankSelect i_bankSelect (
		.cpuAddress     (cpuAddress),
		.cpuRnw         (cpuRnw),
		.cpuPhi1        (cpuPhi1),
		.beebRomSel     (beebRomSel),
		.integraRomSel  (integraRomSel),
		.romNumber      (romNumber),
		.privEn         (privEn),
		.memSel         (memSel),
		.privS8         (privS8),
		.privS4         (privS4),
		.privS1         (privS1),
		.shEn           (shEn),
		.writeProt      (writeProt),
		.page           (page),
		.romRead        (romRead),
		.nRomBankSel0to3(nRomBankSel0to3),
		.nRomBankSel    (nRomBankSel),
		.nRamCe         (nRamCe),
		.ramAddress     (ramAddress),
		.nWds           (nWds),
		.nRds           (nRds),
		.nDbufCe        (nDbufCe),
		.nDbufDir       (nDbufDir),
		.toBbcPhi1      (toBbcPhi1),
		.toBbcRnw       (toBbcRnw),
		.toBbcRd0       (toBbcRd0),
		.toBbcRd1       (toBbcRd1),
		.rtcAs          (rtcAs),
		.rtcDs          (rtcDs)
	);

endmodule

`default_nettype wire

// ==== hw/bankSelect.sv ====
`timescale 1ns/10ps
`default_nettype none

module bankSelect import busMapPkg::*, bankMapPkg::*; (
	input  logic [addrWidth-1:0] cpuAddress,
	input  logic                 cpuRnw,
	input  logic                 cpuPhi1,
	input  logic [3:0]           beebRomSel,
	input  logic [7:0]           integraRomSel,
	input  romBankT              romNumber,
	input  logic                 privEn,
	input  logic                 memSel,
	input  logic                 privS8,
	input  logic                 privS4,
	input  logic                 privS1,
	input  logic                 shEn,
	input  logic [15:0]          writeProt,
	input  pageT                 page,
	output logic                 romRead,
	output logic                 nRomBankSel0to3,
	output logic [7:0]           nRomBankSel,
	output logic                 nRamCe,
	output ramBankT              ramAddress,
	output logic                 nWds,
	output logic                 nRds,
	output logic                 nDbufCe,
	output logic                 nDbufDir,
	output logic                 toBbcPhi1,
	output logic                 toBbcRnw,
	output logic                 toBbcRd0,
	output logic                 toBbcRd1,
	output logic                 rtcAs,
	output logic                 rtcDs
);

	logic phi2;
	logic swrAddr;
	logic regPageHit;
	logic privAct;
	logic shAct;
	logic shadowSel;
	logic romDec;
	// Jumper decode of the latched bank, independent of bus timing
	logic beebRom;
	logic socketRom;
	logic beebRomHit;
	logic socketRomHit;
	logic ramBankHit;
	ramBankT swrBank;

	assign phi2 = ~cpuPhi1;
	assign swrAddr = (cpuAddress[15:14] == swrRegion);
	assign regPageHit = (cpuAddress[15:4] == regPage);

	// Private RAM overlays the bottom of the sideways region
	// privS1 covers &8000..&83FF, privS4 &8000..&8FFF and privS8 &9000..&AFFF
	assign privAct = privEn && (
		((cpuAddress[15:12] == 4'h8) && (cpuAddress[11:10] == 2'b00) && privS1) ||
		((cpuAddress[15:12] == 4'h8) && privS4) ||
		((cpuAddress[15:12] == 4'h9) && privS8) ||
		((cpuAddress[15:12] == 4'hA) && privS8));

	// Shadow screen is seen by the CPU only while memSel is clear
	assign shAct = shEn && !memSel &&
		(cpuAddress >= screenStart) && (cpuAddress <= screenEnd);

	assign shadowSel = shAct || privAct;

	// A sideways bank is decoded only during phi2 and outside private RAM
	assign romDec = swrAddr && !privAct && phi2;

	// Banks 0..3 go to the motherboard when their jumper is fitted
	assign beebRom = (romNumber < romBankT'(beebRomCount)) && beebRomSel[romNumber[1:0]];
	// Banks 8..15 go to the board sockets when their jumper is fitted
	assign socketRom = romNumber[3] && integraRomSel[romNumber[2:0]];

	assign beebRomHit = romDec && beebRom;
	assign socketRomHit = romDec && socketRom;
	assign ramBankHit = romDec && !beebRom && !socketRom;

	assign nRomBankSel0to3 = !beebRomHit;
	// One select per socket, bit 0 being socket 8
	assign nRomBankSel = ~({8{socketRomHit}} & (8'b1 << romNumber[2:0]));

	// Reads of bank 10 in RAM drive the pager; phi2 is left out on purpose
	// because the pager samples this level after phi2 has fallen
	assign romRead = swrAddr && !privAct && cpuRnw &&
		(romNumber == palpromBaseBank) && !socketRom;

	// Bank 10 in RAM shows the page picked by the pager
	assign swrBank = (romNumber == palpromBaseBank) ? palpromPageBanks[page] :
		ramBankT'(romNumber);

	// Shadow and private share one 32 KB block, split by address bit 14
	always_comb begin
		if (shadowSel) begin
			ramAddress = cpuAddress[14] ? shadowHighBank : shadowLowBank;
		end else begin
			ramAddress = swrBank;
		end
	end

	assign nRamCe = !(ramBankHit || shadowSel);

	// Write strobe honours the soft protect of the decoded bank
	// Shadow and private RAM can always be written
	assign nWds = !(!cpuRnw && phi2 && ((romDec && writeProt[romNumber]) || shadowSel));
	assign nRds = !(cpuRnw && phi2);

	// Data buffer carries onboard sideways, shadow and register traffic
	// It stays off while a motherboard ROM drives the bus itself
	assign nDbufCe = !((swrAddr && !beebRomHit) || shadowSel || regPageHit);
	assign nDbufDir = cpuRnw;

	// Shadow cycles are hidden from the motherboard by holding phi1 and RnW high
	assign toBbcPhi1 = cpuPhi1 || shAct;
	assign toBbcRnw = cpuRnw || shAct;

	// Motherboard ROM select lines come from the two low latch bits
	assign toBbcRd0 = romNumber[0];
	assign toBbcRd1 = romNumber[1];

	// Clock chip address strobe at &FE38 and data strobe at &FE3C..&FE3F
	assign rtcAs = regPageHit && (cpuAddress[3:0] == rtcAddrOffset) && phi2 && !cpuRnw;
	assign rtcDs = regPageHit && (cpuAddress[3:2] == rtcDataSel) && phi2;

endmodule

`default_nettype wire

// ==== hw/palpromPager.sv ====
`timescale 1ns/10ps
`default_nettype none

module palpromPager import busMapPkg::*, bankMapPkg::*; (
	input  logic                 cc4Clk,
	input  logic                 bbc_nRST,
	input  logic                 cycleEnd,
	input  logic [addrWidth-1:0] cycleAddr,
	input  logic                 cycleRead,
	input  logic                 romRead,
	output pageT                 page
);

	// Address prefix of the finished cycle, compared against the trigger ranges
	logic [triggerWidth-1:0] cyclePrefix;
	// Set when the finished cycle was a read out of the paged image
	logic pagedRead;

	assign cyclePrefix = cycleAddr[addrWidth-1 -: triggerWidth];

	// The live address has not moved yet at cycleEnd
	// So romRead still describes the cycle that just finished
	assign pagedRead = cycleEnd && cycleRead && romRead;

	// Any read from a trigger range flips the upper 8 KB of the image
	// Reads elsewhere in the bank keep the current page
	always_ff @(posedge cc4Clk) begin
		if (!bbc_nRST) begin
			page <= 2'd0;
		end else if (pagedRead) begin
			case (cyclePrefix)
				pageTrigger0: page <= 2'd0;
				pageTrigger1: page <= 2'd1;
				pageTrigger2: page <= 2'd2;
				pageTrigger3: page <= 2'd3;
				default: page <= page;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/boardRegisters.sv ====
`timescale 1ns/10ps
`default_nettype none

module boardRegisters import busMapPkg::*, bankMapPkg::*; (
	input  logic                 cc4Clk,
	input  logic                 bbc_nRST,
	input  logic                 cycleEnd,
	input  logic [addrWidth-1:0] cycleAddr,
	input  ctlByteT              cycleData,
	input  logic                 cycleRead,
	input  logic [addrWidth-1:0] cpuAddress,
	input  logic                 cpuPhi1,
	input  logic                 cpuRnw,
	input  logic [15:0]          ramWriteProt,
	output romBankT              romNumber,
	output logic                 privEn,
	output logic                 memSel,
	output logic                 privS8,
	output logic                 privS4,
	output logic                 privS1,
	output logic                 shEn,
	output logic [15:0]          writeProt,
	output logic [dataWidth-1:0] dataOut,
	output logic                 dataOutEn
);

	// Captured write landing in the register page
	logic pageWrite;
	// Live read of one of the two write protect bytes
	logic readWpLow;
	logic readWpHigh;
	logic livePage;

	assign pageWrite = cycleEnd && !cycleRead && (cycleAddr[15:4] == regPage);

	// Register writes take effect on the clock that carries cycleEnd
	// Address bits 1..0 are ignored for the two latches, as on the real board
	always_ff @(posedge cc4Clk) begin
		if (!bbc_nRST) begin
			romNumber <= '0;
			privEn <= 1'b0;
			memSel <= 1'b0;
		end else if (pageWrite && (cycleAddr[3:2] == romLatchSel)) begin
			romNumber <= cycleData.romLatchView.romNum;
			privEn <= cycleData.romLatchView.privEn;
			memSel <= cycleData.romLatchView.memSel;
		end
	end

	// Private window sizes and the shadow enable share the second latch
	always_ff @(posedge cc4Clk) begin
		if (!bbc_nRST) begin
			privS8 <= 1'b0;
			privS4 <= 1'b0;
			privS1 <= 1'b0;
			shEn <= 1'b0;
		end else if (pageWrite && (cycleAddr[3:2] == accessCtlSel)) begin
			privS8 <= cycleData.accessCtlView.privS8;
			privS4 <= cycleData.accessCtlView.privS4;
			privS1 <= cycleData.accessCtlView.privS1;
			shEn <= cycleData.accessCtlView.shEn;
		end
	end

	// Soft write protect, a 1 bit lets the bank be written
	// The jumpers fit low to enable, so reset loads their inverse
	always_ff @(posedge cc4Clk) begin
		if (!bbc_nRST) begin
			writeProt <= ~ramWriteProt;
		end else if (pageWrite && (cycleAddr[3:0] == wpLowOffset)) begin
			writeProt[7:0] <= cycleData;
		end else if (pageWrite && (cycleAddr[3:0] == wpHighOffset)) begin
			writeProt[15:8] <= cycleData;
		end
	end

	// Readback follows the live bus, so the CPU sees data within the same phi2
	assign livePage = (cpuAddress[15:4] == regPage);
	assign readWpLow = livePage && (cpuAddress[3:0] == wpLowOffset) && cpuRnw && !cpuPhi1;
	assign readWpHigh = livePage && (cpuAddress[3:0] == wpHighOffset) && cpuRnw && !cpuPhi1;

	assign dataOutEn = readWpLow || readWpHigh;
	assign dataOut = readWpHigh ? writeProt[15:8] : writeProt[7:0];

endmodule

`default_nettype wire

// ==== hw/busCycleCapture.sv ====
`timescale 1ns/10ps
`default_nettype none

module busCycleCapture import busMapPkg::*; (
	input  logic                 cc4Clk,
	input  logic                 bbc_nRST,
	input  logic                 cpuPhi1,
	input  logic                 cpuRnw,
	input  logic [addrWidth-1:0] cpuAddress,
	input  logic [dataWidth-1:0] cpuData,
	output logic                 cycleEnd,
	output logic [addrWidth-1:0] cycleAddr,
	output ctlByteT              cycleData,
	output logic                 cycleRead
);

	// The CPU drives phi1 only, phi2 is its complement
	logic phi2;
	// Phi2 as sampled on the previous clock edge
	logic phi2Prev;

	assign phi2 = ~cpuPhi1;

	// Track the phi2 level and flag the first clock of the falling phase
	// The pulse lasts exactly one clock because phi2Prev follows phi2 at once
	always_ff @(posedge cc4Clk) begin
		if (!bbc_nRST) begin
			phi2Prev <= 1'b0;
			cycleEnd <= 1'b0;
		end else begin
			phi2Prev <= phi2;
			cycleEnd <= phi2Prev & ~phi2;
		end
	end

	// Keep re-sampling the bus for as long as phi2 is high
	// What remains at the end is the last phi2 high sample of the cycle
	// These registers then hold still through the whole phi1 half
	always_ff @(posedge cc4Clk) begin
		if (phi2) begin
			cycleAddr <= cpuAddress;
			cycleData <= cpuData;
			cycleRead <= cpuRnw;
		end
	end

endmodule

`default_nettype wire

// ==== hw/bankMapPkg.sv ====
`default_nettype none

package bankMapPkg;

	// Sideways bank number as held in the paged ROM latch
	typedef logic [3:0] romBankT;

	// RAM bank index, driven straight onto RAM address lines 18..14
	typedef logic [4:0] ramBankT;

	// Active page of the four page ROM image
	typedef logic [1:0] pageT;

	// The 32 KB shadow and private block sits above the 16 sideways banks
	// Address bit 14 picks the lower or the upper half
	localparam ramBankT shadowLowBank = 5'd16;
	localparam ramBankT shadowHighBank = 5'd17;

	// Motherboard ROM sockets occupy banks 0..3
	localparam int beebRomCount = 4;

	// The paged ROM image lives in bank 10
	localparam romBankT palpromBaseBank = 4'd10;

	// RAM bank shown for each page, page 0 being the base bank itself
	localparam ramBankT palpromPageBanks [0:3] = '{5'd10, 5'd22, 5'd23, 5'd24};

	// Trigger ranges are 32 bytes long, so only address bits 15..5 are compared
	localparam int triggerWidth = 11;

	// &9340..&935F selects page 0
	localparam logic [triggerWidth-1:0] pageTrigger0 = 11'b1001_0011_010;
	// &91E0..&91FF selects page 1
	localparam logic [triggerWidth-1:0] pageTrigger1 = 11'b1001_0001_111;
	// &8820..&883F selects page 2
	localparam logic [triggerWidth-1:0] pageTrigger2 = 11'b1000_1000_001;
	// &92C0..&92DF selects page 3
	localparam logic [triggerWidth-1:0] pageTrigger3 = 11'b1001_0010_110;

endpackage

`default_nettype wire

// ==== hw/busMapPkg.sv ====
`default_nettype none

package busMapPkg;

	// CPU address and data bus widths
	localparam int addrWidth = 16;
	localparam int dataWidth = 8;

	// Upper twelve address bits of the board register page &FE30..&FE3F
	localparam logic [11:0] regPage = 12'hFE3;

	// Register groups decoded from address bits 3..2 within the page
	// Group 0 is the paged ROM latch, group 1 the access control latch
	localparam logic [1:0] romLatchSel = 2'b00;
	localparam logic [1:0] accessCtlSel = 2'b01;
	// Group 3 covers &FE3C..&FE3F, the clock chip data window
	localparam logic [1:0] rtcDataSel = 2'b11;

	// Single register offsets decoded from address bits 3..0
	localparam logic [3:0] rtcAddrOffset = 4'h8;
	localparam logic [3:0] wpLowOffset = 4'hA;
	localparam logic [3:0] wpHighOffset = 4'hB;

	// Top two address bits of the sideways region &8000..&BFFF
	localparam logic [1:0] swrRegion = 2'b10;

	// Screen memory that can be shadowed, inclusive bounds
	localparam logic [addrWidth-1:0] screenStart = 16'h3000;
	localparam logic [addrWidth-1:0] screenEnd = 16'h7FFF;

	// Byte written to the paged ROM latch at &FE30..&FE33
	typedef struct packed {
		logic memSel;
		logic privEn;
		logic [1:0] spare;
		logic [3:0] romNum;
	} romLatchT;

	// Byte written to the access control latch at &FE34..&FE37
	typedef struct packed {
		logic shEn;
		logic privS1;
		logic privS4;
		logic privS8;
		logic [3:0] spare;
	} accessCtlT;

	// One data byte, read by whichever latch the address picked
	typedef union packed {
		romLatchT romLatchView;
		accessCtlT accessCtlView;
	} ctlByteT;

endpackage

`default_nettype wire
